// File: compile.f
+incdir+source
source/mem_map_pkg.sv
source/io_map_pkg.sv
source/bus_sync.sv
source/bank_map.sv
source/io_regs.sv
source/mem_select.sv
source/bus_glue_top.sv
bench/clock_gen.sv
bench/tb_bus_glue_top.sv

// File: Bender.yml
package:
  name: bus_glue

sources:
  - include_dirs:
      - source
    files:
      - source/mem_map_pkg.sv
      - source/io_map_pkg.sv
      - source/bus_sync.sv
      - source/bank_map.sv
      - source/io_regs.sv
      - source/mem_select.sv
      - source/bus_glue_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/clock_gen.sv
      - bench/tb_bus_glue_top.sv

// File: bench/tb_bus_glue_top.sv
`default_nettype none

`include "bus_settings.svh"

module tb_bus_glue_top;

    typedef enum logic [2:0] {IO_WR, IO_RD, IO_PEEK, MEM_RD, MEM_WR} op_e;

    typedef struct packed {
        op_e                    op;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] data;
        logic [63:0]            keys;
        logic [1:0]             pins;       // {cassette_in, printer_in}
        logic [`BUS_DATA_W-1:0] exp_data;
        logic                   exp_oe;
        logic [2:0]             exp_ce_n;   // {rom, cart, ram}
        logic [`BA_W-1:0]       exp_ba;
        logic [10:0]            exp_out;    // {cassette, printer, cpm, scramble}
    } entry_t;

    localparam logic [2:0] CE_NONE = 3'b111;
    localparam logic [2:0] CE_ROM  = 3'b011;
    localparam logic [2:0] CE_CART = 3'b101;
    localparam logic [2:0] CE_RAM  = 3'b110;

    logic                   sysclk;
    logic                   reset;
    logic [`BUS_ADDR_W-1:0] ebus_a;
    logic [`BUS_DATA_W-1:0] ebus_d_in;
    logic [`BUS_DATA_W-1:0] ebus_d_out;
    logic                   ebus_d_oe;
    logic                   ebus_rd_n;
    logic                   ebus_wr_n;
    logic                   ebus_mreq_n;
    logic                   ebus_iorq_n;
    logic [`BA_W-1:0]       ebus_ba;
    logic                   ebus_rom_ce_n;
    logic                   ebus_cart_ce_n;
    logic                   ebus_ram_ce_n;
    logic                   cassette_in;
    logic                   cassette_out;
    logic                   printer_in;
    logic                   printer_out;
    logic [63:0]            keys;
    logic                   cpm_remap;
    logic [`BUS_DATA_W-1:0] scramble_value;

    entry_t      entries [64];
    int          n_entries;
    int          cur_entry;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] rng_state;
    logic [63:0] cur_keys;      // Stimulus and outputs carried into each new entry
    logic [1:0]  cur_pins;
    logic [10:0] cur_out;

    clock_gen #(.PERIOD(8), .RESET_CYCLES(16)) clock_gen (.sysclk(sysclk), .reset(reset));

    bus_glue_top UUT (
        .sysclk         (sysclk),
        .reset          (reset),
        .ebus_a         (ebus_a),
        .ebus_d_in      (ebus_d_in),
        .ebus_d_out     (ebus_d_out),
        .ebus_d_oe      (ebus_d_oe),
        .ebus_rd_n      (ebus_rd_n),
        .ebus_wr_n      (ebus_wr_n),
        .ebus_mreq_n    (ebus_mreq_n),
        .ebus_iorq_n    (ebus_iorq_n),
        .ebus_ba        (ebus_ba),
        .ebus_rom_ce_n  (ebus_rom_ce_n),
        .ebus_cart_ce_n (ebus_cart_ce_n),
        .ebus_ram_ce_n  (ebus_ram_ce_n),
        .cassette_in    (cassette_in),
        .cassette_out   (cassette_out),
        .printer_in     (printer_in),
        .printer_out    (printer_out),
        .keys           (keys),
        .cpm_remap      (cpm_remap),
        .scramble_value (scramble_value)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Every row whose address line is low pulls its zero keys into the result
    function logic [7:0] key_and(input logic [63:0] k, input logic [7:0] sel);
        logic [7:0] result;
        result = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (sel[row] == 1'b0) result = result & k[row*8 +: 8];
        end
        return result;
    endfunction

    task check_value(input string what, input logic [63:0] actual, input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %0t: entry %0d %s is %0h, expected %0h",
                     $time, cur_entry, what, actual, expected);
            $display("Something failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task add_entry(input op_e op, input logic [15:0] addr, input logic [7:0] data,
                   input logic [7:0] exp_data, input logic exp_oe,
                   input logic [2:0] exp_ce_n, input logic [`BA_W-1:0] exp_ba);
        entries[n_entries] = {op, addr, data, cur_keys, cur_pins,
                              exp_data, exp_oe, exp_ce_n, exp_ba, cur_out};
        n_entries++;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task build_table();
        logic [31:0] rnd;
        logic [7:0]  sel;
        cur_keys = '1;
        cur_pins = 2'b00;
        cur_out  = '0;
        // Reset values of the banks
        add_entry(IO_RD,  16'h00F0, 8'h00, 8'hC0, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_RD,  16'h00F1, 8'h00, 8'h21, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_RD,  16'h00F2, 8'h00, 8'h22, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_RD,  16'h00F3, 8'h00, 8'h13, 1'b1, CE_NONE, 5'd0);
        add_entry(MEM_RD, 16'h0000, 8'h00, 8'h00, 1'b0, CE_ROM,  5'd0);
        add_entry(MEM_RD, 16'h4000, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd1);
        add_entry(MEM_RD, 16'hC000, 8'h00, 8'h00, 1'b0, CE_CART, 5'd19);
        // Page changes
        add_entry(IO_WR,  16'h00F1, 8'h05, 8'h00, 1'b0, CE_NONE, 5'd0);
        add_entry(MEM_RD, 16'h4000, 8'h00, 8'h00, 1'b0, CE_ROM,  5'd5);
        add_entry(IO_RD,  16'h00F1, 8'h00, 8'h05, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_WR,  16'h00F1, 8'h11, 8'h00, 1'b0, CE_NONE, 5'd0);
        add_entry(MEM_RD, 16'h4123, 8'h00, 8'h00, 1'b0, CE_CART, 5'd17);
        add_entry(IO_WR,  16'h00F2, 8'h28, 8'h00, 1'b0, CE_NONE, 5'd0);
        add_entry(MEM_RD, 16'h8000, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd8);
        add_entry(MEM_WR, 16'h8000, 8'h5A, 8'h00, 1'b0, CE_RAM,  5'd8);
        add_entry(IO_WR,  16'h00F3, 8'h14, 8'h00, 1'b0, CE_NONE, 5'd0);
        add_entry(MEM_RD, 16'hC000, 8'h00, 8'h00, 1'b0, CE_NONE, 5'd20);
        // Overlay window and write protect, bank 0 still RO + overlay
        add_entry(MEM_RD, 16'h3800, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd0);
        add_entry(MEM_RD, 16'h3FFF, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd0);
        add_entry(MEM_WR, 16'h3800, 8'h33, 8'h00, 1'b0, CE_RAM,  5'd0);
        add_entry(MEM_WR, 16'h0000, 8'h33, 8'h00, 1'b0, CE_NONE, 5'd0);
        add_entry(MEM_RD, 16'h0000, 8'h00, 8'h00, 1'b0, CE_ROM,  5'd0);
        add_entry(IO_WR,  16'h00F2, 8'h68, 8'h00, 1'b0, CE_NONE, 5'd0);   // Overlay, page 40
        add_entry(MEM_RD, 16'hB800, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd0);
        add_entry(MEM_RD, 16'hB000, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd8);
        add_entry(IO_WR,  16'h00F2, 8'hA8, 8'h00, 1'b0, CE_NONE, 5'd0);   // RO, page 40
        add_entry(MEM_WR, 16'h8000, 8'h77, 8'h00, 1'b0, CE_NONE, 5'd8);
        add_entry(MEM_RD, 16'h8000, 8'h00, 8'h00, 1'b0, CE_RAM,  5'd8);
        // Small IO ports
        cur_out[10] = 1'b1;
        add_entry(IO_WR,  16'h00FC, 8'h01, 8'h00, 1'b0, CE_NONE, 5'd0);
        cur_out[8] = 1'b1;
        add_entry(IO_WR,  16'h00FD, 8'h01, 8'h00, 1'b0, CE_NONE, 5'd0);
        cur_out[9] = 1'b1;
        add_entry(IO_WR,  16'h00FE, 8'h01, 8'h00, 1'b0, CE_NONE, 5'd0);
        cur_out[7:0] = 8'hA5;
        add_entry(IO_WR,  16'h00FF, 8'hA5, 8'h00, 1'b0, CE_NONE, 5'd0);
        cur_pins = 2'b10;
        add_entry(IO_RD,  16'h00FC, 8'h00, 8'h01, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_RD,  16'h00FE, 8'h00, 8'h00, 1'b1, CE_NONE, 5'd0);
        cur_pins = 2'b01;
        add_entry(IO_RD,  16'h00FC, 8'h00, 8'h00, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_RD,  16'h00FE, 8'h00, 8'h01, 1'b1, CE_NONE, 5'd0);
        add_entry(IO_RD,  16'h00FD, 8'h00, 8'h00, 1'b1, CE_NONE, 5'd0);
        cur_out[10] = 1'b0;     // Only bit 0 counts
        add_entry(IO_WR,  16'h00FC, 8'hFE, 8'h00, 1'b0, CE_NONE, 5'd0);
        // Keyboard matrix
        for (int i = 0; i < 8; i++) begin
            cur_keys = {lcg_next(), lcg_next()};
            rnd      = lcg_next();
            sel      = rnd[23:16];
            add_entry(IO_RD, {sel, 8'hFF}, 8'h00, key_and(cur_keys, sel), 1'b1, CE_NONE, 5'd0);
        end
        add_entry(IO_RD,   16'hFFFF, 8'h00, 8'hFF, 1'b1, CE_NONE, 5'd0);  // No row
        add_entry(IO_RD,   16'h00FF, 8'h00, key_and(cur_keys, 8'h00), 1'b1, CE_NONE, 5'd0);
        add_entry(IO_PEEK, 16'h00FF, 8'h00, 8'h00, 1'b0, CE_NONE, 5'd0);  // RD high
    endtask

    // Strobes low for 5 cycles, then high for 3
    task apply_entry(input entry_t e);
        @(posedge sysclk);
        ebus_a                    <= e.addr;
        ebus_d_in                 <= e.data;
        keys                      <= e.keys;
        {cassette_in, printer_in} <= e.pins;
        ebus_iorq_n <= !(e.op == IO_WR || e.op == IO_RD || e.op == IO_PEEK);
        ebus_mreq_n <= !(e.op == MEM_RD || e.op == MEM_WR);
        ebus_rd_n   <= !(e.op == IO_RD || e.op == MEM_RD);
        ebus_wr_n   <= !(e.op == IO_WR || e.op == MEM_WR);
        @(negedge sysclk);
        check_value("chip enables", {ebus_rom_ce_n, ebus_cart_ce_n, ebus_ram_ce_n}, e.exp_ce_n);
        check_value("ebus_d_oe", ebus_d_oe, e.exp_oe);
        if (e.op == IO_RD) check_value("ebus_d_out", ebus_d_out, e.exp_data);
        if (e.op == MEM_RD || e.op == MEM_WR) check_value("ebus_ba", ebus_ba, e.exp_ba);
        repeat (5) @(posedge sysclk);
        ebus_iorq_n <= 1'b1;
        ebus_mreq_n <= 1'b1;
        ebus_rd_n   <= 1'b1;
        ebus_wr_n   <= 1'b1;
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        check_value("cassette_out", cassette_out, e.exp_out[10]);
        check_value("printer_out", printer_out, e.exp_out[9]);
        check_value("cpm_remap", cpm_remap, e.exp_out[8]);
        check_value("scramble_value", scramble_value, e.exp_out[7:0]);
    endtask

    ////////////////////////////////////////////////////////////
    // Run
    ////////////////////////////////////////////////////////////

    initial begin
        ebus_a      <= '0;
        ebus_d_in   <= '0;
        ebus_rd_n   <= 1'b1;
        ebus_wr_n   <= 1'b1;
        ebus_mreq_n <= 1'b1;
        ebus_iorq_n <= 1'b1;
        cassette_in <= 1'b0;
        printer_in  <= 1'b0;
        keys        <= '1;
        rng_state   = 32'd17;
        n_entries   = 0;
        build_table();
        cycle_limit = n_entries * 8 + 16 + 32;   // Reset plus some slack
        wait (reset === 1'b0);
        for (cur_entry = 0; cur_entry < n_entries; cur_entry++) begin
            apply_entry(entries[cur_entry]);
        end
        $display("Everything OK");
        $finish;
    end

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic sysclk,
    output logic reset
);

    initial begin
        sysclk = 1'b0;
        forever #(PERIOD / 2) sysclk = ~sysclk;
    end

    // Release on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge sysclk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: source/bus_glue_top.sv
`default_nettype none

`include "bus_settings.svh"

module bus_glue_top
    import mem_map_pkg::*;
(
    input  wire logic                   sysclk,
    input  wire logic                   reset,

    // Z80 bus
    input  wire logic [`BUS_ADDR_W-1:0] ebus_a,
    input  wire logic [`BUS_DATA_W-1:0] ebus_d_in,
    output logic      [`BUS_DATA_W-1:0] ebus_d_out,
    output logic                        ebus_d_oe,
    input  wire logic                   ebus_rd_n,
    input  wire logic                   ebus_wr_n,
    input  wire logic                   ebus_mreq_n,
    input  wire logic                   ebus_iorq_n,
    output logic      [`BA_W-1:0]       ebus_ba,
    output logic                        ebus_rom_ce_n,
    output logic                        ebus_cart_ce_n,
    output logic                        ebus_ram_ce_n,

    // Peripherals
    input  wire logic                   cassette_in,
    output logic                        cassette_out,
    input  wire logic                   printer_in,
    output logic                        printer_out,
    input  wire logic [63:0]            keys,
    output logic                        cpm_remap,
    output logic      [`BUS_DATA_W-1:0] scramble_value
);

    logic [`BUS_DATA_W-1:0] wr_data;
    logic                   bus_write;
    bank_reg_t              cur_bank;
    logic                   bank_rd_sel;
    logic [`BUS_DATA_W-1:0] bank_rddata;
    logic                   io_rd_sel;
    logic [`BUS_DATA_W-1:0] io_rddata;

    ////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////

    bus_sync bus_sync (
        .sysclk    (sysclk),
        .reset     (reset),
        .ebus_wr_n (ebus_wr_n),
        .ebus_d_in (ebus_d_in),
        .wr_data   (wr_data),
        .bus_write (bus_write)
    );

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    bank_map bank_map (
        .sysclk      (sysclk),
        .reset       (reset),
        .ebus_a      (ebus_a),
        .ebus_iorq_n (ebus_iorq_n),
        .wr_data     (wr_data),
        .bus_write   (bus_write),
        .cur_bank    (cur_bank),
        .bank_rd_sel (bank_rd_sel),
        .bank_rddata (bank_rddata)
    );

    io_regs io_regs (
        .sysclk         (sysclk),
        .reset          (reset),
        .ebus_a         (ebus_a),
        .ebus_iorq_n    (ebus_iorq_n),
        .wr_data        (wr_data),
        .bus_write      (bus_write),
        .cassette_in    (cassette_in),
        .printer_in     (printer_in),
        .keys           (keys),
        .cassette_out   (cassette_out),
        .printer_out    (printer_out),
        .cpm_remap      (cpm_remap),
        .scramble_value (scramble_value),
        .io_rd_sel      (io_rd_sel),
        .io_rddata      (io_rddata)
    );

    // Output side
    mem_select mem_select (
        .ebus_a         (ebus_a),
        .ebus_mreq_n    (ebus_mreq_n),
        .ebus_rd_n      (ebus_rd_n),
        .ebus_wr_n      (ebus_wr_n),
        .cur_bank       (cur_bank),
        .bank_rd_sel    (bank_rd_sel),
        .bank_rddata    (bank_rddata),
        .io_rd_sel      (io_rd_sel),
        .io_rddata      (io_rddata),
        .ebus_ba        (ebus_ba),
        .ebus_rom_ce_n  (ebus_rom_ce_n),
        .ebus_cart_ce_n (ebus_cart_ce_n),
        .ebus_ram_ce_n  (ebus_ram_ce_n),
        .ebus_d_out     (ebus_d_out),
        .ebus_d_oe      (ebus_d_oe)
    );

endmodule

`default_nettype wire

// File: source/mem_select.sv
`default_nettype none

`include "bus_settings.svh"

module mem_select
    import mem_map_pkg::*;
(
    input  wire logic [`BUS_ADDR_W-1:0] ebus_a,
    input  wire logic                   ebus_mreq_n,
    input  wire logic                   ebus_rd_n,
    input  wire logic                   ebus_wr_n,
    input  wire bank_reg_t              cur_bank,
    input  wire logic                   bank_rd_sel,
    input  wire logic [`BUS_DATA_W-1:0] bank_rddata,
    input  wire logic                   io_rd_sel,
    input  wire logic [`BUS_DATA_W-1:0] io_rddata,
    output logic      [`BA_W-1:0]       ebus_ba,
    output logic                        ebus_rom_ce_n,
    output logic                        ebus_cart_ce_n,
    output logic                        ebus_ram_ce_n,
    output logic      [`BUS_DATA_W-1:0] ebus_d_out,
    output logic                        ebus_d_oe
);

    localparam page_t sysram_page = `SYSRAM_PAGE;

    page_t page;
    logic  sel_sysram;
    logic  allow_mem;

    assign page = cur_bank.fields.page;

    // $3800-$3FFF of the bank window when overlay is on
    assign sel_sysram = !ebus_mreq_n && cur_bank.fields.overlay && ebus_a[13:11] == 3'b111;

    // Write protect blocks the chip enable on writes only
    assign allow_mem = !ebus_mreq_n && !sel_sysram && (ebus_wr_n || !cur_bank.fields.ro);

    assign ebus_rom_ce_n  = !(allow_mem && page < `CART_FIRST_PAGE);
    assign ebus_cart_ce_n = !(allow_mem && page >= `CART_FIRST_PAGE
                                        && page <= `CART_LAST_PAGE);
    assign ebus_ram_ce_n  = !((allow_mem && page >= sysram_page) || sel_sysram);

    assign ebus_ba = sel_sysram ? sysram_page[`BA_W-1:0] : page[`BA_W-1:0];

    // Internal read data from either register block
    assign ebus_d_out = bank_rd_sel ? bank_rddata :
                        io_rd_sel   ? io_rddata   : '0;
    assign ebus_d_oe  = !ebus_rd_n && (bank_rd_sel || io_rd_sel);

endmodule

`default_nettype wire

// File: source/io_regs.sv
`default_nettype none

`include "bus_settings.svh"

module io_regs
    import io_map_pkg::*;
(
    input  wire logic                   sysclk,
    input  wire logic                   reset,
    input  wire logic [`BUS_ADDR_W-1:0] ebus_a,
    input  wire logic                   ebus_iorq_n,
    input  wire logic [`BUS_DATA_W-1:0] wr_data,
    input  wire logic                   bus_write,
    input  wire logic                   cassette_in,
    input  wire logic                   printer_in,
    input  wire logic [63:0]            keys,
    output logic                        cassette_out,
    output logic                        printer_out,
    output logic                        cpm_remap,
    output logic      [`BUS_DATA_W-1:0] scramble_value,
    output logic                        io_rd_sel,
    output logic      [`BUS_DATA_W-1:0] io_rddata
);

    logic                   sel_cassette;
    logic                   sel_cpm;
    logic                   sel_printer;
    logic                   sel_keyb;
    logic [`BUS_DATA_W-1:0] keyb_rddata;

    // Port decode
    assign sel_cassette = !ebus_iorq_n && ebus_a[7:0] == CASSETTE;
    assign sel_cpm      = !ebus_iorq_n && ebus_a[7:0] == CPM_VSYNC;
    assign sel_printer  = !ebus_iorq_n && ebus_a[7:0] == PRINTER;
    assign sel_keyb     = !ebus_iorq_n && ebus_a[7:0] == KEYB_SCRAMBLE;

    assign io_rd_sel = sel_cassette || sel_cpm || sel_printer || sel_keyb;

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cassette_out   <= 1'b0;
            cpm_remap      <= 1'b0;
            printer_out    <= 1'b0;
            scramble_value <= '0;
        end else if (bus_write) begin
            if (sel_cassette) cassette_out   <= wr_data[0];
            if (sel_cpm)      cpm_remap      <= wr_data[0];
            if (sel_printer)  printer_out    <= wr_data[0];
            if (sel_keyb)     scramble_value <= wr_data;
        end
    end

    // Key rows are active low, A15..A8 low selects a row
    always_comb begin
        keyb_rddata = '1;
        for (int row = 0; row < 8; row++) begin
            if (!ebus_a[8 + row]) begin
                keyb_rddata &= keys[row*8 +: 8];
            end
        end
    end

    // Read mux
    always_comb begin
        io_rddata = '0;                 // $FD reads 00 now that vsync is gone
        if (sel_cassette) io_rddata = {{(`BUS_DATA_W-1){1'b0}}, cassette_in};
        if (sel_printer)  io_rddata = {{(`BUS_DATA_W-1){1'b0}}, printer_in};
        if (sel_keyb)     io_rddata = keyb_rddata;
    end

endmodule

`default_nettype wire

// File: source/bank_map.sv
`default_nettype none

`include "bus_settings.svh"

module bank_map
    import mem_map_pkg::*, io_map_pkg::*;
(
    input  wire logic                   sysclk,
    input  wire logic                   reset,
    input  wire logic [`BUS_ADDR_W-1:0] ebus_a,
    input  wire logic                   ebus_iorq_n,
    input  wire logic [`BUS_DATA_W-1:0] wr_data,
    input  wire logic                   bus_write,
    output bank_reg_t                   cur_bank,
    output logic                        bank_rd_sel,
    output logic      [`BUS_DATA_W-1:0] bank_rddata
);

    bank_reg_t  bank_q [4];     // IO $F0-$F3
    logic [1:0] io_idx;

    // Low address bits pick the register, same for read and write
    assign io_idx = ebus_a[1:0];

    ////////////////////////////////////////////////////////////
    // IO decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        bank_rd_sel = 1'b0;
        if (!ebus_iorq_n) begin
            case (ebus_a[7:0])
                BANK0, BANK1, BANK2, BANK3: bank_rd_sel = 1'b1;
                default:                    bank_rd_sel = 1'b0;
            endcase
        end
    end

    // Registers
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_q[0].raw <= `BANK0_RESET;
            bank_q[1].raw <= `BANK1_RESET;
            bank_q[2].raw <= `BANK2_RESET;
            bank_q[3].raw <= `BANK3_RESET;
        end else if (bank_rd_sel && bus_write) begin
            bank_q[io_idx].raw <= wr_data;
        end
    end

    // Raw readback
    assign bank_rddata = bank_q[io_idx].raw;

    ////////////////////////////////////////////////////////////
    // Current bank for memory cycles
    ////////////////////////////////////////////////////////////

    // 16K window per bank
    assign cur_bank = bank_q[ebus_a[15:14]];

endmodule

`default_nettype wire

// File: source/bus_sync.sv
`default_nettype none

`include "bus_settings.svh"

module bus_sync (
    input  wire logic                   sysclk,
    input  wire logic                   reset,
    input  wire logic                   ebus_wr_n,
    input  wire logic [`BUS_DATA_W-1:0] ebus_d_in,
    output logic      [`BUS_DATA_W-1:0] wr_data,
    output logic                        bus_write
);

    logic [`SYNC_STAGES-1:0] wr_n_sr;   // Oldest sample in the top bit

    // WR strobe into sysclk, idle high
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_sr <= '1;
        end else begin
            wr_n_sr <= {wr_n_sr[`SYNC_STAGES-2:0], ebus_wr_n};
        end
    end

    // Last byte seen while WR is low
    always_ff @(posedge sysclk) begin
        if (!ebus_wr_n) begin
            wr_data <= ebus_d_in;
        end
    end

    // Falling edge of the synchronised strobe
    assign bus_write = wr_n_sr[`SYNC_STAGES-1] && !wr_n_sr[`SYNC_STAGES-2];

endmodule

`default_nettype wire

// File: source/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

    // Internal IO port addresses, low byte of the bus address
    typedef enum logic [7:0] {
        BANK0         = 8'hF0,
        BANK1         = 8'hF1,
        BANK2         = 8'hF2,
        BANK3         = 8'hF3,
        CASSETTE      = 8'hFC,  // R: cassette in, W: cassette out
        CPM_VSYNC     = 8'hFD,  // R: 00, W: CP/M remap
        PRINTER       = 8'hFE,  // R: printer in, W: printer out
        KEYB_SCRAMBLE = 8'hFF   // R: key matrix, W: scramble value
    } io_port_e;

endpackage

`default_nettype wire

// File: source/mem_map_pkg.sv
`default_nettype none

`include "bus_settings.svh"

package mem_map_pkg;

    // Bank page number
    typedef logic [`PAGE_W-1:0] page_t;

    // Field view of a bank register
    typedef struct packed {
        logic  ro;          // Block memory writes
        logic  overlay;     // Map $x800 window of 2K to sysram
        page_t page;
    } bank_fields_t;

    // Raw byte for IO readback, fields for memory decode
    typedef union packed {
        logic [`BUS_DATA_W-1:0] raw;
        bank_fields_t           fields;
    } bank_reg_t;

endpackage

`default_nettype wire

// File: source/bus_settings.svh
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

// Z80 address and data
`define BUS_ADDR_W      16
`define BUS_DATA_W      8

// Bank page number and physical bank address
`define PAGE_W          6
`define BA_W            5

////////////////////////////////////////////////////////////
// Bank register reset values
////////////////////////////////////////////////////////////

// Layout is {ro, overlay, page[5:0]}
`define BANK0_RESET     8'hC0   // RO + overlay, page 0
`define BANK1_RESET     8'h21   // Page 33
`define BANK2_RESET     8'h22   // Page 34
`define BANK3_RESET     8'h13   // Page 19

////////////////////////////////////////////////////////////
// Page numbers
////////////////////////////////////////////////////////////

`define SYSRAM_PAGE     6'd32   // Overlay target, also first RAM page
`define CART_FIRST_PAGE 6'd16
`define CART_LAST_PAGE  6'd19

// WR strobe shift register length
`define SYNC_STAGES     3

`endif
